// File: Bender.yml
package:
  name: canvas_top

sources:
  - gfx_pkg.sv
  - draw_line.sv
  - draw_triangle.sv
  - render_triangles.sv
  - pixel_buffer.sv
  - canvas_top.sv
  - target: test
    files:
      - canvas_chk.sv
      - tb_canvas_top.sv

// File: canvas_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// canvas checker: pixel range, drawing vs clear,
// done held until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module canvas_chk (
    input logic            clk,
    input logic            rst,
    input logic            drawing,
    input logic            done,
    input logic            clearing,
    input gfx_pkg::pixel_t pix
);
    import gfx_pkg::*;

    int unsigned fail_cnt = 0;   // failed assertions so far

    // every strobed pixel is on the canvas
    pix_in_canvas: assert property (
        @(posedge clk) disable iff (rst)
        drawing |-> (pix.x >= 0 && pix.x < canvas_w && pix.y >= 0 && pix.y < canvas_h)
    ) else begin
        fail_cnt++;
        $error("pixel outside the canvas");
    end

    no_draw_in_clear: assert property (
        @(posedge clk) disable iff (rst)
        !(drawing && clearing)
    ) else begin
        fail_cnt++;
        $error("drawing strobe during the clear sweep");
    end

    // sticky until the next reset
    done_sticky: assert property (
        @(posedge clk) disable iff (rst)
        done |=> done
    ) else begin
        fail_cnt++;
        $error("done fell without a reset");
    end

endmodule

// File: canvas_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// canvas top: triangle renderer feeding the frame buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module canvas_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              oe,
    input  gfx_pkg::fb_addr_t rd_addr,
    output gfx_pkg::cidx_t    rd_data,
    output gfx_pkg::pixel_t   pix,
    output logic              drawing,
    output logic              busy,
    output logic              done,
    output logic              clearing
);

    logic render_start;

    // no rendering until the buffer is clean
    assign render_start = start && !clearing;

    render_triangles u_render (
        .clk,
        .rst,
        .oe,
        .start   (render_start),
        .pix,
        .drawing,
        .busy,
        .done
    );

    pixel_buffer u_fb (
        .clk,
        .rst,
        .wr_en    (drawing),   // one write per drawn pixel
        .wr_pix   (pix),
        .rd_addr,
        .rd_data,
        .clearing
    );

endmodule

// File: compile.f
gfx_pkg.sv
draw_line.sv
draw_triangle.sv
render_triangles.sv
pixel_buffer.sv
canvas_top.sv
canvas_chk.sv
tb_canvas_top.sv

// File: draw_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line drawer: integer Bresenham, one pixel per
// cycle while oe is high, endpoints ordered top to bottom
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module draw_line (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,    // begin a new line
    input  logic             oe,       // low stalls the output
    input  gfx_pkg::vertex_t p0,
    input  gfx_pkg::vertex_t p1,
    output gfx_pkg::coord_t  x,        // current point
    output gfx_pkg::coord_t  y,
    output logic             drawing,  // pixel valid this cycle
    output logic             busy,
    output logic             done      // one cycle after last pixel
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {idle, setup, step} state_t;

    state_t                  state;
    vertex_t                 pa;       // upper endpoint
    vertex_t                 pb;       // lower endpoint
    coord_t                  sx;       // x step of +1 or -1
    coord_t                  dx;       // always >= 0
    coord_t                  dy;       // always <= 0
    coord_t                  dx_n;
    coord_t                  dy_n;
    logic signed [cordw:0]   err;
    logic signed [cordw+1:0] err2;
    logic                    swap;
    logic                    movx;
    logic                    movy;
    logic                    last;

    always_comb begin
        swap = p0.y > p1.y;   // draw downwards only
        dx_n = (pb.x > pa.x) ? pb.x - pa.x : pa.x - pb.x;
        dy_n = pa.y - pb.y;
        err2 = {err, 1'b0};
        movx = err2 >= dy;
        movy = err2 <= dx;
        last = (x == pb.x) && (y == pb.y);
    end

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) state <= setup;
                end
                setup: begin
                    state <= step;
                end
                step: begin
                    if (oe && last) begin
                        state <= idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // endpoint capture and stepping
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    pa <= swap ? p1 : p0;
                    pb <= swap ? p0 : p1;
                end
            end
            setup: begin
                dx  <= dx_n;
                dy  <= dy_n;
                err <= dx_n + dy_n;
                sx  <= (pb.x > pa.x) ? coord_t'(1) : -coord_t'(1);
                x   <= pa.x;
                y   <= pa.y;
            end
            step: begin
                if (oe && !last) begin
                    if (movx) x <= x + sx;
                    if (movy) y <= y + coord_t'(1);
                    if (movx && movy) err <= err + dx + dy;
                    else if (movx) err <= err + dy;
                    else if (movy) err <= err + dx;
                end
            end
            default: ;
        endcase
    end

    assign drawing = (state == step) && oe;
    assign busy    = state != idle;

endmodule

// File: draw_triangle.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// triangle outline drawer: runs the line drawer
// over v0-v1, v1-v2 and v2-v0 in turn
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module draw_triangle (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             oe,
    input  gfx_pkg::vertex_t v0,
    input  gfx_pkg::vertex_t v1,
    input  gfx_pkg::vertex_t v2,
    output gfx_pkg::coord_t  x,
    output gfx_pkg::coord_t  y,
    output logic             drawing,
    output logic             busy,
    output logic             done
);
    import gfx_pkg::*;

    typedef enum logic [2:0] {idle, edge0, edge1, edge2, finish} state_t;

    state_t  state;
    vertex_t lp0;          // endpoints of the current edge
    vertex_t lp1;
    logic    line_start;
    logic    line_busy;
    logic    line_done;

    // edge endpoints follow the state
    always_comb begin
        case (state)
            edge1: begin
                lp0 = v1;
                lp1 = v2;
            end
            edge2: begin
                lp0 = v2;
                lp1 = v0;
            end
            default: begin
                lp0 = v0;
                lp1 = v1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state      <= edge0;
                        line_start <= 1'b1;
                    end
                end
                edge0: begin
                    if (line_done) begin
                        state      <= edge1;
                        line_start <= 1'b1;
                    end
                end
                edge1: begin
                    if (line_done) begin
                        state      <= edge2;
                        line_start <= 1'b1;
                    end
                end
                edge2: begin
                    if (line_done) state <= finish;
                end
                default: state <= idle;   // finish lasts one cycle
            endcase
        end
    end

    draw_line u_line (
        .clk,
        .rst,
        .start   (line_start),
        .oe,
        .p0      (lp0),
        .p1      (lp1),
        .x,
        .y,
        .drawing,
        .busy    (line_busy),
        .done    (line_done)
    );

    assign busy = (state != idle) || line_busy;
    assign done = state == finish;

endmodule

// File: gfx_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// graphics package: canvas geometry, widths,
// coordinate and colour types for the triangle renderer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package gfx_pkg;

    localparam int cordw     = 16;   // signed coordinate width
    localparam int cidxw     = 4;    // colour index width
    localparam int scale     = 1;    // drawing scale, 1 gives 320x180
    localparam int canvas_w  = 320;  // canvas width in pixels
    localparam int canvas_h  = 180;  // canvas height in pixels
    localparam int npix      = canvas_w * canvas_h;
    localparam int addrw     = 16;   // covers 57600 pixels
    localparam int shape_cnt = 3;    // triangles in the scene

    typedef logic signed [cordw-1:0] coord_t;
    typedef logic [cidxw-1:0]        cidx_t;
    typedef logic [addrw-1:0]        fb_addr_t;

    // one triangle corner or line endpoint
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // one drawn pixel with its colour
    typedef struct packed {
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pixel_t;

endpackage

// File: pixel_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame buffer: clears to colour 0 after reset,
// then stores drawn pixels, registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pixel_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  gfx_pkg::pixel_t   wr_pix,
    input  gfx_pkg::fb_addr_t rd_addr,
    output gfx_pkg::cidx_t    rd_data,   // one cycle after rd_addr
    output logic              clearing   // clear sweep in progress
);
    import gfx_pkg::*;

    cidx_t    mem [npix];
    fb_addr_t clr_addr;
    fb_addr_t wr_addr;
    logic     in_range;

    always_comb begin
        wr_addr  = fb_addr_t'(wr_pix.y * canvas_w + wr_pix.x);   // row major
        in_range = (wr_pix.x >= 0) && (wr_pix.x < canvas_w) &&
                   (wr_pix.y >= 0) && (wr_pix.y < canvas_h);
    end

    // clear sweep, one address per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == fb_addr_t'(npix - 1)) clearing <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= '0;
        end else if (wr_en && in_range) begin
            mem[wr_addr] <= wr_pix.cidx;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: render_triangles.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scene sequencer: draws the three triangle
// outlines of the fixed scene, each in its own colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module render_triangles (
    input  logic            clk,
    input  logic            rst,
    input  logic            oe,
    input  logic            start,
    output gfx_pkg::pixel_t pix,      // valid while drawing
    output logic            drawing,
    output logic            busy,
    output logic            done      // stays high until reset
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {idle, init, draw, complete} state_t;

    state_t     state;
    logic [1:0] shape_id;
    vertex_t    v0;
    vertex_t    v1;
    vertex_t    v2;
    cidx_t      cidx;
    coord_t     px;
    coord_t     py;
    logic       tri_start;
    logic       tri_busy;
    logic       tri_done;

    function automatic vertex_t scaled(input int vx, input int vy);
        vertex_t v;
        v.x = coord_t'(vx * scale);
        v.y = coord_t'(vy * scale);
        return v;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            shape_id  <= '0;
            tri_start <= 1'b0;
        end else begin
            tri_start <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state    <= init;
                        shape_id <= '0;
                    end
                end
                init: begin
                    tri_start <= 1'b1;   // vertices loaded this cycle
                    state     <= draw;
                end
                draw: begin
                    if (tri_done) begin
                        if (shape_id == 2'(shape_cnt - 1)) begin
                            state <= complete;
                        end else begin
                            shape_id <= shape_id + 2'd1;
                            state    <= init;
                        end
                    end
                end
                default: state <= complete;   // only reset leaves here
            endcase
        end
    end

    // shape table
    always_ff @(posedge clk) begin
        if (state == init) begin
            case (shape_id)
                2'd0: begin
                    v0   <= scaled(30, 10);
                    v1   <= scaled(140, 40);
                    v2   <= scaled(80, 82);
                    cidx <= cidx_t'(3);
                end
                2'd1: begin
                    v0   <= scaled(35, 80);
                    v1   <= scaled(110, 45);
                    v2   <= scaled(85, 5);
                    cidx <= cidx_t'(2);
                end
                default: begin
                    v0   <= scaled(11, 18);
                    v1   <= scaled(31, 75);
                    v2   <= scaled(49, 48);
                    cidx <= cidx_t'(1);
                end
            endcase
        end
    end

    draw_triangle u_tri (
        .clk,
        .rst,
        .start   (tri_start),
        .oe,
        .v0,
        .v1,
        .v2,
        .x       (px),
        .y       (py),
        .drawing,
        .busy    (tri_busy),
        .done    (tri_done)
    );

    always_comb begin
        pix.x    = px;
        pix.y    = py;
        pix.cidx = cidx;
    end

    assign busy = tri_busy || (state == init) || (state == draw);
    assign done = state == complete;

endmodule

// File: tb_canvas_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for canvas_top: clear, render, frame buffer
// readback, edge endpoints and oe stalling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_canvas_top;
    import gfx_pkg::*;

    localparam int max_cycles = 120000;   // two clears plus two renders and margin

    logic     clk = 1'b0;
    logic     rst;
    logic     start;
    logic     oe;
    fb_addr_t rd_addr;
    cidx_t    rd_data;
    pixel_t   pix;
    logic     drawing;
    logic     busy;
    logic     done;
    logic     clearing;

    int       seed = 48;
    int       cycles = 0;
    pixel_t   pix_q[$];     // strobes of the current render
    pixel_t   first_q[$];   // strobes of the unstalled render

    // unscaled reference scene
    int shape_x [3][3] = '{'{30, 140, 80}, '{35, 110, 85}, '{11, 31, 49}};
    int shape_y [3][3] = '{'{10, 40, 82}, '{80, 45, 5}, '{18, 75, 48}};
    int shape_col [3]  = '{3, 2, 1};

    canvas_top u_dut (
        .clk,
        .rst,
        .start,
        .oe,
        .rd_addr,
        .rd_data,
        .pix,
        .drawing,
        .busy,
        .done,
        .clearing
    );

    bind canvas_top canvas_chk u_chk (
        .clk,
        .rst,
        .drawing,
        .done,
        .clearing,
        .pix
    );

    always #50 clk = ~clk;

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_eq(input string name, input logic signed [63:0] expected,
                            input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    // cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            stop_run();
        end
    end

    // failures flagged by the bound checker
    always @(negedge clk) begin
        if (u_dut.u_chk.fail_cnt != 0) begin
            $display("an assertion on canvas_top failed");
            stop_run();
        end
    end

    // strobes are sampled before the edge updates the DUT
    always @(posedge clk) begin
        if (!rst && drawing) begin
            check_eq("strobe with oe low", 1, oe);
            pix_q.push_back(pix);
        end
    end

    function automatic int edge_len(input int ax, input int ay, input int bx, input int by);
        int adx;
        int ady;
        adx = (ax > bx) ? ax - bx : bx - ax;
        ady = (ay > by) ? ay - by : by - ay;
        return ((adx > ady) ? adx : ady) + 1;
    endfunction

    function automatic int vert_x(input int s, input int k);
        return shape_x[s][k % 3] * scale;
    endfunction

    function automatic int vert_y(input int s, input int k);
        return shape_y[s][k % 3] * scale;
    endfunction

    function automatic int total_pixels();
        int n;
        n = 0;
        for (int s = 0; s < 3; s++) begin
            for (int e = 0; e < 3; e++) begin
                n += edge_len(vert_x(s, e), vert_y(s, e), vert_x(s, e + 1), vert_y(s, e + 1));
            end
        end
        return n;
    endfunction

    task automatic apply_reset();
        rst   = 1'b1;
        start = 1'b0;
        oe    = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    // one start pulse, then wait for done
    task automatic run_render(input bit random_oe);
        pix_q.delete();
        start = 1'b1;
        do begin
            @(negedge clk);
            start = 1'b0;
            if (!done) check_eq("busy while rendering", 1, busy);
            if (random_oe) oe = ($random(seed) & 3) != 0;   // about a quarter stalled
        end while (!done);
        oe = 1'b1;
    endtask

    task automatic read_colour(input int px, input int py, output cidx_t colour);
        rd_addr = fb_addr_t'(py * canvas_w + px);
        @(negedge clk);   // registered read takes one edge
        colour = rd_data;
    endtask

    task automatic test_reset_clear();
        int cnt;
        check_eq("reset drawing", 0, drawing);
        check_eq("reset busy", 0, busy);
        check_eq("reset done", 0, done);
        check_eq("reset clearing", 1, clearing);
        cnt   = 0;
        start = 1'b1;   // must be ignored
        do begin
            @(negedge clk);
            start = 1'b0;
            cnt++;
            check_eq("drawing during clear", 0, drawing);
            check_eq("done during clear", 0, done);
        end while (clearing);
        check_eq("clear length", canvas_w * canvas_h, cnt);
        repeat (5) @(negedge clk);
        check_eq("busy after ignored start", 0, busy);
        check_eq("done after ignored start", 0, done);
    endtask

    task automatic test_full_render();
        int pos;
        int n;
        run_render(1'b0);
        check_eq("render done", 1, done);
        check_eq("busy after done", 0, busy);
        check_eq("render strobe count", total_pixels(), pix_q.size());
        pos = 0;
        for (int s = 0; s < 3; s++) begin
            for (int e = 0; e < 3; e++) begin
                n = edge_len(vert_x(s, e), vert_y(s, e), vert_x(s, e + 1), vert_y(s, e + 1));
                for (int i = 0; i < n; i++) begin
                    check_eq($sformatf("render colour shape %0d", s), shape_col[s],
                             pix_q[pos + i].cidx);
                end
                pos += n;
            end
        end
        first_q = pix_q;
    endtask

    task automatic test_edge_endpoints();
        int pos;
        int n;
        int ax;
        int ay;
        int bx;
        int by;
        pos = 0;
        for (int s = 0; s < 3; s++) begin
            for (int e = 0; e < 3; e++) begin
                ax = vert_x(s, e);
                ay = vert_y(s, e);
                bx = vert_x(s, e + 1);
                by = vert_y(s, e + 1);
                n  = edge_len(ax, ay, bx, by);
                if (ay > by) begin   // drawn downwards, so the ends swap
                    ax = vert_x(s, e + 1);
                    ay = vert_y(s, e + 1);
                    bx = vert_x(s, e);
                    by = vert_y(s, e);
                end
                check_eq($sformatf("edge %0d.%0d first x", s, e), ax, first_q[pos].x);
                check_eq($sformatf("edge %0d.%0d first y", s, e), ay, first_q[pos].y);
                check_eq($sformatf("edge %0d.%0d last x", s, e), bx, first_q[pos + n - 1].x);
                check_eq($sformatf("edge %0d.%0d last y", s, e), by, first_q[pos + n - 1].y);
                pos += n;
            end
        end
    endtask

    task automatic test_frame_buffer();
        cidx_t colour;
        for (int k = 0; k < 3; k++) begin
            read_colour(vert_x(2, k), vert_y(2, k), colour);
            check_eq($sformatf("fb vertex %0d of shape 2", k), 1, colour);
        end
        read_colour(0, 0, colour);
        check_eq("fb corner 0,0", 0, colour);
        read_colour(canvas_w - 1, canvas_h - 1, colour);
        check_eq("fb corner 319,179", 0, colour);
    endtask

    task automatic test_stall_restart();
        int n;
        apply_reset();
        do @(negedge clk); while (clearing);
        run_render(1'b1);
        check_eq("stall strobe count", first_q.size(), pix_q.size());
        for (int i = 0; i < first_q.size(); i++) begin
            check_eq($sformatf("stall pixel %0d", i), first_q[i], pix_q[i]);
        end
        n     = pix_q.size();
        start = 1'b1;   // second start after done
        @(negedge clk);
        start = 1'b0;
        repeat (40) @(negedge clk);
        check_eq("restart strobe count", n, pix_q.size());
        check_eq("restart done", 1, done);
    endtask

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        oe      = 1'b1;
        rd_addr = '0;
        apply_reset();
        test_reset_clear();
        test_full_render();
        test_edge_endpoints();
        test_frame_buffer();
        test_stall_restart();
        $display("Test OK");
        $finish;
    end

endmodule
